// File: src/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    // op codes live in instr[23:21], op[2] is the address mode
    // 0 = register (mar drives the address bus), 1 = immediate (ir[15:0] does)
    localparam logic [2:0] op_dev_eq_alu      = 3'd0; // targ = lbus <aluop> rbus
    localparam logic [2:0] op_dev_eq_const8   = 3'd1; // targ = rom constant
    localparam logic [2:0] op_devp_eq_const16 = 3'd2; // pair load, behaves as op 1
    localparam logic [2:0] op_dev_eq_rom_abs  = 3'd4; // targ = rom[abs]
    localparam logic [2:0] op_dev_eq_ram_abs  = 3'd5; // targ = ram[abs]
    localparam logic [2:0] op_ram_abs_eq_dev  = 3'd6; // ram[abs] = lbus device
    // codes 3 and 7 have no meaning and get trapped

    localparam int dev_w  = 4; // rbus / lbus device select
    localparam int targ_w = 5; // write target select
    localparam int alu_w  = 5; // alu function

    localparam logic [dev_w-1:0]  dev_rom   = 4'h0;
    localparam logic [dev_w-1:0]  dev_ram   = 4'h2;
    localparam logic [dev_w-1:0]  dev_none  = 4'hf;  // nobody drives the bus
    localparam logic [targ_w-1:0] targ_ram  = 5'h02;
    localparam logic [targ_w-1:0] targ_none = 5'h1f; // no register latches

    localparam logic [alu_w-1:0] alu_nop    = 5'd0;
    localparam logic [alu_w-1:0] alu_pass_l = 5'd1;
    localparam logic [alu_w-1:0] alu_pass_r = 5'd2;

    // phase ring, one instruction = seq_len clocks
    localparam int seq_len          = 10;
    localparam int seq_fetch_first  = 0;
    localparam int seq_fetch_last   = 2;
    localparam int seq_decode_first = 3;
    localparam int seq_decode_last  = 4;
    localparam int seq_exec_first   = 5;
    localparam int seq_exec_last    = 9;
    localparam int seq_ir_load      = 2; // ir captures fetch data at end of this step
    localparam int seq_pc_step      = 9; // pc bumps at end of this step

    // program store and apb map
    localparam int instr_w     = 24;
    localparam int prog_depth  = 256;
    localparam int prog_addr_w = $clog2(prog_depth);
    localparam int apb_addr_w  = 12;
    localparam int apb_data_w  = 32;

    localparam logic [apb_addr_w-1:0] apb_ctrl_addr   = 12'h400; // bit 0 = run
    localparam logic [apb_addr_w-1:0] apb_status_addr = 12'h404; // {illegal, pc}

    // register form, used by op 0
    typedef struct packed {
        logic [2:0]        op;
        logic [targ_w-1:0] targ;
        logic [2:0]        spare;
        logic [dev_w-1:0]  lbus;
        logic [dev_w-1:0]  rbus;
        logic [alu_w-1:0]  aluop;
    } reg_form_t;

    // immediate form, op 6 also pulls its lbus device out of targ
    typedef struct packed {
        logic [2:0]        op;
        logic [targ_w-1:0] targ;
        logic [15:0]       addr;
    } imm_form_t;

    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instr_u;

    // decoded controls out to the datapath, enables are active low
    typedef struct packed {
        logic              addrmode_pc_n;
        logic              addrmode_register_n;
        logic              addrmode_direct_n;
        logic [dev_w-1:0]  rbus_dev;
        logic [dev_w-1:0]  lbus_dev;
        logic [targ_w-1:0] targ_dev;
        logic [alu_w-1:0]  aluop;
        logic [15:0]       abs_addr;
    } ctrl_out_t;

    typedef struct packed {
        logic [seq_len-1:0] seq; // one-hot step
        logic               fetch;
        logic               decode;
        logic               exec;
    } phase_t;

endpackage

`default_nettype wire

// File: src/phaser.sv
`default_nettype none

module phaser (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  run,   // host run bit, holds the ring when low
    output cpu_ctrl_pkg::phase_t phase
);
    import cpu_ctrl_pkg::*;

    logic [seq_len-1:0] ring; // one-hot, bit n = step n
    logic               fetch_now;
    logic               decode_now;
    logic               exec_now;

    // ring counter, a single token walks up one step per clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ring                  <= '0;
            ring[seq_fetch_first] <= 1'b1; // park on first fetch step
        end else if (run) begin
            ring <= {ring[seq_len-2:0], ring[seq_len-1]}; // step 9 wraps to 0
        end
    end

    // phase flags are plain ors over each step range
    assign fetch_now  = |ring[seq_fetch_last:seq_fetch_first];
    assign decode_now = |ring[seq_decode_last:seq_decode_first];
    assign exec_now   = |ring[seq_exec_last:seq_exec_first];

    always_comb begin
        phase.seq    = ring;
        phase.fetch  = fetch_now;  // pc on the address bus
        phase.decode = decode_now; // ir valid, selects settling
        phase.exec   = exec_now;   // selects held for the datapath
    end

endmodule

`default_nettype wire

// File: src/control.sv
`default_nettype none

module control (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire cpu_ctrl_pkg::phase_t                 phase,
    input  wire [cpu_ctrl_pkg::instr_w-1:0]           fetch_data,  // registered store read
    output logic [cpu_ctrl_pkg::prog_addr_w-1:0]      fetch_addr,
    output logic [cpu_ctrl_pkg::prog_addr_w-1:0]      pc,
    output logic                                      illegal,     // sticky bad-op flag
    output cpu_ctrl_pkg::ctrl_out_t                   ctrl
);
    import cpu_ctrl_pkg::*;

    instr_u            ir;          // instruction register
    logic              pc_stepped;  // pc already bumped on this visit to the last step
    logic              prog_phase;  // decode or exec
    logic              mode_imm;    // instr bit 23
    logic              op_bad;      // op 3 or 7
    logic [dev_w-1:0]  rbus_sel;
    logic [dev_w-1:0]  lbus_sel;
    logic [targ_w-1:0] targ_sel;
    logic [alu_w-1:0]  alu_sel;
    logic [15:0]       abs_sel;

    // the store sees the pc directly, its word is back one clock later
    assign fetch_addr = pc;

    // ir loads at the end of the last fetch step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (phase.seq[seq_ir_load]) begin
            ir <= fetch_data;
        end
    end

    // pc bumps once per visit to the last step
    // a ring held there by run=0 must not keep counting
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= '0;
            pc_stepped <= 1'b0;
        end else begin
            pc_stepped <= phase.seq[seq_pc_step];
            if (phase.seq[seq_pc_step] && !pc_stepped) begin
                pc <= pc + 1'b1; // wraps at prog_depth
            end
        end
    end

    // bad op is caught on the first decode step and stays until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            illegal <= 1'b0;
        end else if (phase.seq[seq_decode_first] && op_bad) begin
            illegal <= 1'b1;
        end
    end

    assign mode_imm   = ir.reg_form.op[2];
    assign prog_phase = phase.decode | phase.exec;

    // op decode, everything idles unless the op says otherwise
    always_comb begin
        rbus_sel = dev_none;
        lbus_sel = dev_none;
        targ_sel = targ_none;
        alu_sel  = alu_nop;
        abs_sel  = '0;
        op_bad   = 1'b0;
        case (ir.reg_form.op)
            op_dev_eq_alu: begin
                // full register form, every field from the word
                rbus_sel = ir.reg_form.rbus;
                lbus_sel = ir.reg_form.lbus;
                alu_sel  = ir.reg_form.aluop;
                targ_sel = ir.reg_form.targ;
            end
            op_dev_eq_const8, op_devp_eq_const16: begin
                rbus_sel = dev_rom;    // constant comes off the rom bus
                alu_sel  = alu_pass_r;
                targ_sel = ir.reg_form.targ;
            end
            op_dev_eq_rom_abs: begin
                rbus_sel = dev_rom;
                alu_sel  = alu_pass_r;
                targ_sel = ir.imm_form.targ;
                abs_sel  = ir.imm_form.addr; // rom indexed by the ir, not live rom
            end
            op_dev_eq_ram_abs: begin
                rbus_sel = dev_ram;
                alu_sel  = alu_pass_r;
                targ_sel = ir.imm_form.targ;
                abs_sel  = ir.imm_form.addr;
            end
            op_ram_abs_eq_dev: begin
                lbus_sel = ir.imm_form.targ[dev_w-1:0]; // source device in bits 19:16
                alu_sel  = alu_pass_l;
                targ_sel = targ_ram;
                abs_sel  = ir.imm_form.addr;
            end
            default: begin
                op_bad = 1'b1; // leave everything idle
            end
        endcase
    end

    // address mode enables, exactly one low at a time
    // selects only leave idle once the ir holds this instruction
    always_comb begin
        ctrl.addrmode_pc_n       = ~phase.fetch;
        ctrl.addrmode_register_n = ~(prog_phase & ~mode_imm);
        ctrl.addrmode_direct_n   = ~(prog_phase & mode_imm);
        ctrl.rbus_dev            = prog_phase ? rbus_sel : dev_none;
        ctrl.lbus_dev            = prog_phase ? lbus_sel : dev_none;
        ctrl.targ_dev            = prog_phase ? targ_sel : targ_none;
        ctrl.aluop               = prog_phase ? alu_sel : alu_nop;
        ctrl.abs_addr            = prog_phase ? abs_sel : '0;
    end

endmodule

`default_nettype wire

// File: src/prog_host.sv
`default_nettype none

module prog_host (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire [cpu_ctrl_pkg::apb_addr_w-1:0]   paddr,
    input  wire [cpu_ctrl_pkg::apb_data_w-1:0]   pwdata,
    input  wire [cpu_ctrl_pkg::prog_addr_w-1:0]  fetch_addr,
    input  wire [cpu_ctrl_pkg::prog_addr_w-1:0]  pc,
    input  wire                                  illegal,
    output logic [cpu_ctrl_pkg::apb_data_w-1:0]  prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic [cpu_ctrl_pkg::instr_w-1:0]     fetch_data,
    output logic                                 run
);
    import cpu_ctrl_pkg::*;

    logic [instr_w-1:0]     prog_mem [prog_depth]; // program store
    logic                   access;     // apb access phase
    logic                   wr_en;
    logic                   hit_prog;
    logic                   hit_ctrl;
    logic                   hit_status;
    logic [prog_addr_w-1:0] word_idx;

    assign access   = psel & penable;
    assign wr_en    = access & pwrite;
    assign word_idx = paddr[prog_addr_w+1:2]; // byte address -> word

    // map decode
    // program words sit at 0x000..0x3fc and must be word aligned
    assign hit_prog   = (paddr[apb_addr_w-1:prog_addr_w+2] == '0) && (paddr[1:0] == 2'b00);
    assign hit_ctrl   = (paddr == apb_ctrl_addr);
    assign hit_status = (paddr == apb_status_addr);

    // host side write port plus registered fetch read
    always_ff @(posedge clk) begin
        if (wr_en && hit_prog) begin
            prog_mem[word_idx] <= pwdata[instr_w-1:0]; // upper byte dropped
        end
        fetch_data <= prog_mem[fetch_addr];
    end

    // run bit, the only thing that stops the sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (wr_en && hit_ctrl) begin
            run <= pwdata[0];
        end
    end

    // read mux, zero wait states so data is ready in the access phase
    always_comb begin
        prdata = '0;
        if (hit_prog) begin
            prdata = apb_data_w'(prog_mem[word_idx]); // zero extended
        end else if (hit_ctrl) begin
            prdata[0] = run;
        end else if (hit_status) begin
            prdata[prog_addr_w-1:0] = pc;
            prdata[prog_addr_w]     = illegal; // bit 8
        end
    end

    assign pready  = 1'b1;
    assign pslverr = access & ~(hit_prog | hit_ctrl | hit_status); // hole in the map

endmodule

`default_nettype wire

// File: src/cpu_ctrl_top.sv
`default_nettype none

module cpu_ctrl_top (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire [cpu_ctrl_pkg::apb_addr_w-1:0]   paddr,
    input  wire [cpu_ctrl_pkg::apb_data_w-1:0]   pwdata,
    output wire [cpu_ctrl_pkg::apb_data_w-1:0]   prdata,
    output wire                                  pready,
    output wire                                  pslverr,
    output wire cpu_ctrl_pkg::ctrl_out_t         ctrl,   // to the datapath
    output wire cpu_ctrl_pkg::phase_t            phase   // sequencer state, also feeds control
);
    import cpu_ctrl_pkg::*;

    wire                   run;
    wire [prog_addr_w-1:0] fetch_addr;
    wire [instr_w-1:0]     fetch_data;
    wire [prog_addr_w-1:0] pc;
    wire                   illegal;

    // host port, program store and run/status registers
    prog_host prog_host_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .fetch_addr (fetch_addr),
        .pc         (pc),
        .illegal    (illegal),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fetch_data (fetch_data),
        .run        (run)
    );

    phaser phaser_i (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .phase (phase)
    );

    // ir, pc and op decode
    control control_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .fetch_data (fetch_data),
        .fetch_addr (fetch_addr),
        .pc         (pc),
        .illegal    (illegal),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

// File: dv/cpu_ctrl_props.sv
`default_nettype none

module cpu_ctrl_props (
    input wire                          clk,
    input wire                          rst_n,
    input wire cpu_ctrl_pkg::phase_t    phase,
    input wire cpu_ctrl_pkg::instr_u    ir,
    input wire cpu_ctrl_pkg::ctrl_out_t ctrl
);
    import cpu_ctrl_pkg::*;

    int fail_cnt = 0; // property failures so far

    // a single token walks the ring
    seq_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(phase.seq))
        else begin
            $error("phase.seq lost its single token");
            fail_cnt++;
        end

    // pc, register or direct, never two and never none
    mode_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot({~ctrl.addrmode_pc_n, ~ctrl.addrmode_register_n, ~ctrl.addrmode_direct_n}))
        else begin
            $error("address mode enables not exactly one low");
            fail_cnt++;
        end

    // ir only moves on the load step
    ir_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !phase.seq[seq_ir_load] |=> $stable(ir))
        else begin
            $error("ir changed outside the load step");
            fail_cnt++;
        end

endmodule

bind control cpu_ctrl_props props_i (
    .clk   (clk),
    .rst_n (rst_n),
    .phase (phase),
    .ir    (ir),
    .ctrl  (ctrl)
);

`default_nettype wire

// File: dv/cpu_ctrl_tb.sv
`default_nettype none

module cpu_ctrl_tb;
    import cpu_ctrl_pkg::*;

    localparam int n_words    = 40; // words in the program image
    localparam int bad_slot   = 20; // op 3 lives here
    localparam int stop_pc    = 36; // host stops during this instruction
    localparam int max_cycles = 40 * seq_len + 6 * n_words + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    wire  [apb_data_w-1:0] prdata;
    wire                   pready;
    wire                   pslverr;
    wire ctrl_out_t        ctrl;
    wire phase_t           phase;

    logic [instr_w-1:0] prog_img [prog_depth]; // what the host wrote
    logic               run_exp;               // run bit as the host left it
    int                 step_exp;              // expected ring position
    logic [7:0]         pc_exp;
    logic [instr_w-1:0] ir_exp;
    int                 cycles = 0;

    cpu_ctrl_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl),
        .phase   (phase)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [2:0] legal_op(int unsigned r);
        logic [2:0] op;
        case (r % 6)
            0:       op = op_dev_eq_alu;
            1:       op = op_dev_eq_const8;
            2:       op = op_devp_eq_const16;
            3:       op = op_dev_eq_rom_abs;
            4:       op = op_dev_eq_ram_abs;
            default: op = op_ram_abs_eq_dev;
        endcase
        return op;
    endfunction

    // flags follow the step ranges of the ring
    function automatic phase_t expect_phase(int step);
        phase_t p;
        p.seq       = '0;
        p.seq[step] = 1'b1;
        p.fetch     = (step <= seq_fetch_last);
        p.decode    = (step >= seq_decode_first) && (step <= seq_decode_last);
        p.exec      = (step >= seq_exec_first);
        return p;
    endfunction

    // decode table built from bit slices of the word
    function automatic ctrl_out_t expect_ctrl(logic [instr_w-1:0] w, int step);
        ctrl_out_t c;
        logic      busy;
        busy                  = (step > seq_fetch_last); // decode or exec
        c.addrmode_pc_n       = busy;
        c.addrmode_register_n = !(busy && !w[23]);
        c.addrmode_direct_n   = !(busy && w[23]);
        c.rbus_dev            = dev_none;
        c.lbus_dev            = dev_none;
        c.targ_dev            = targ_none;
        c.aluop               = alu_nop;
        c.abs_addr            = 16'h0;
        if (busy) begin
            case (w[23:21])
                op_dev_eq_alu: begin
                    c.rbus_dev = w[8:5];
                    c.lbus_dev = w[12:9];
                    c.targ_dev = w[20:16];
                    c.aluop    = w[4:0];
                end
                op_dev_eq_const8, op_devp_eq_const16, op_dev_eq_rom_abs: begin
                    c.rbus_dev = dev_rom;
                    c.targ_dev = w[20:16];
                    c.aluop    = alu_pass_r;
                    if (w[23]) c.abs_addr = w[15:0]; // only op 4 is absolute
                end
                op_dev_eq_ram_abs: begin
                    c.rbus_dev = dev_ram;
                    c.targ_dev = w[20:16];
                    c.aluop    = alu_pass_r;
                    c.abs_addr = w[15:0];
                end
                op_ram_abs_eq_dev: begin
                    c.lbus_dev = w[19:16]; // source overlaps targ field
                    c.targ_dev = targ_ram;
                    c.aluop    = alu_pass_l;
                    c.abs_addr = w[15:0];
                end
                default: ; // 3 and 7 stay idle
            endcase
        end
        return c;
    endfunction

    task automatic apb_write(input logic [apb_addr_w-1:0] addr,
                             input logic [apb_data_w-1:0] data, input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1; // setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1; // access phase
        @(negedge clk);
        check_val("pslverr", exp_err, pslverr);
        @(posedge clk); // transfer completes on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
        if (addr == apb_ctrl_addr) run_exp <= data[0];
        if (addr < apb_ctrl_addr) prog_img[addr[9:2]] = data[instr_w-1:0];
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] addr,
                            input logic [apb_data_w-1:0] exp_data, input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        pwdata  <= '0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_val("pready", 1'b1, pready); // zero wait states
        check_val("pslverr", exp_err, pslverr);
        if (!exp_err) check_val("prdata", exp_data, prdata);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // reference sequencer where pc counts completed instructions
    always @(posedge clk) begin
        if (!rst_n) begin
            step_exp <= 0;
            pc_exp   <= '0;
            ir_exp   <= '0;
        end else begin
            if (run_exp) begin
                step_exp <= (step_exp == seq_len - 1) ? 0 : step_exp + 1;
                if (step_exp == seq_len - 1) pc_exp <= pc_exp + 8'd1;
            end
            if (step_exp == seq_ir_load) ir_exp <= prog_img[pc_exp];
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_val("phase", expect_phase(step_exp), phase);
            check_val("ctrl", expect_ctrl(ir_exp, step_exp), ctrl);
            assert (dut_i.control_i.props_i.fail_cnt == 0) else begin
                $display("a property bound into control failed before %0t", $time);
                abort_run();
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout, run still going after %0d cycles", max_cycles);
            abort_run();
        end
    end

    initial begin
        int unsigned r;
        void'($urandom(32'h37ab));
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        run_exp  = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // load the program with junk in the top byte that must be dropped
        for (int i = 0; i < n_words; i++) begin
            r = $urandom;
            if (i == bad_slot) r[23:21] = 3'd3;
            else r[23:21] = legal_op($urandom);
            apb_write(apb_addr_w'(i * 4), r, 1'b0);
        end
        for (int i = 0; i < n_words; i++) begin
            apb_read(apb_addr_w'(i * 4), {8'h00, prog_img[i]}, 1'b0);
        end

        apb_read(apb_ctrl_addr, 32'h0, 1'b0);
        apb_read(apb_status_addr, 32'h0, 1'b0);
        apb_read(12'h408, 32'h0, 1'b1);    // hole after status
        apb_write(12'h800, 32'h1, 1'b1);   // off the map so run stays low

        repeat (6) @(posedge clk);         // ring parked on step 0
        apb_write(apb_ctrl_addr, 32'h1, 1'b0);
        apb_read(apb_ctrl_addr, 32'h1, 1'b0);

        // stop mid decode so the ring parks away from the pc step
        while (!(pc_exp == stop_pc && step_exp == seq_decode_first)) @(negedge clk);
        apb_write(apb_ctrl_addr, 32'h0, 1'b0);
        repeat (6) @(posedge clk);
        apb_read(apb_status_addr, {23'h0, 1'b1, 8'(stop_pc % prog_depth)}, 1'b0);

        if (dut_i.control_i.props_i.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("a property bound into control failed near the end of the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: cpu_ctrl_top.f
src/cpu_ctrl_pkg.sv
src/phaser.sv
src/control.sv
src/prog_host.sv
src/cpu_ctrl_top.sv
dv/cpu_ctrl_props.sv
dv/cpu_ctrl_tb.sv
